//--- logic/cart_defines.svh
`ifndef CART_DEFINES_SVH
`define CART_DEFINES_SVH

// ==============================
// Download stream
// ==============================

// Host download bus widths
`define DL_ADDR_BITS      25
`define DL_DATA_BITS      16

// Copier header in front of the ROM image
`define HDR_SKIP          25'd512

// Offsets of the ROM size field for each cartridge layout
// The RAM size field sits two bytes further on
`define LOROM_HDR         25'h000_7FD6
`define HIROM_HDR         25'h000_FFD6
`define EXHIROM_HDR       25'h040_FFD6

// ==============================
// Memories
// ==============================

// Work RAM is byte addressed, backup RAM word addressed
`define WRAM_ADDR_BITS    17
`define BSRAM_ADDR_BITS   16
`define SECTOR_WORDS_BITS 8

// Power-on fill bytes, high byte first for the paired patterns
`define FILL_A            16'h6699
`define FILL_B            16'hFF00
`define FILL_C            8'h55

`endif

//--- logic/cart_pkg.sv
`include "cart_defines.svh"

package cart_pkg;

	// ==============================
	// Payload types
	// ==============================

	// Work RAM byte
	typedef logic [7:0] byte_t;

	// Backup RAM word and download word
	typedef logic [`DL_DATA_BITS-1:0] word_t;

	// Byte address mask for ROM and RAM
	typedef logic [23:0] mask_t;

	// Sector number on the host side
	typedef logic [31:0] lba_t;

	// ==============================
	// Option encodings
	// ==============================

	// Header layout choice
	typedef logic [2:0] hdr_sel_t;
	localparam hdr_sel_t HDR_AUTO    = 3'd0;
	localparam hdr_sel_t HDR_NOHDR   = 3'd1;
	localparam hdr_sel_t HDR_LOROM   = 3'd2;
	localparam hdr_sel_t HDR_HIROM   = 3'd3;
	localparam hdr_sel_t HDR_EXHIROM = 3'd4;

	// Work RAM power-on pattern
	typedef logic [1:0] wram_init_t;
	localparam wram_init_t WRAM_INIT_6699 = 2'd0;
	localparam wram_init_t WRAM_INIT_FF00 = 2'd1;
	localparam wram_init_t WRAM_INIT_55   = 2'd2;
	localparam wram_init_t WRAM_INIT_FF   = 2'd3;

endpackage

//--- logic/cart_header_detect.sv
`timescale 1ns/1ps
`include "cart_defines.svh"

module cart_header_detect
	import cart_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  logic                     cart_dl,
	input  logic [`DL_ADDR_BITS-1:0] dl_addr,
	input  word_t                    dl_data,
	input  logic                     dl_wr,
	input  hdr_sel_t                 hdr_sel,
	input  logic [1:0]               region_sel,
	output byte_t                    rom_type,
	output mask_t                    rom_mask,
	output mask_t                    ram_mask,
	output logic                     region
);

	logic [3:0]               rom_size;
	logic [3:0]               ram_size;
	logic [3:0]               rom_size_nxt;
	logic [3:0]               ram_size_nxt;
	logic [`DL_ADDR_BITS-1:0] hdr_base;
	logic [`DL_ADDR_BITS-1:0] rom_fld_addr;
	logic [`DL_ADDR_BITS-1:0] ram_fld_addr;
	logic                     hdr_forced;
	logic                     rom_region;
	logic                     hdr_wr;

	assign hdr_wr = cart_dl & dl_wr;

	// Size field location for a forced layout
	// Both LoROM choices read the LoROM offset
	always_comb begin
		hdr_forced = 1'b1;
		case (hdr_sel)
			HDR_NOHDR, HDR_LOROM: hdr_base = `LOROM_HDR;
			HDR_HIROM:            hdr_base = `HIROM_HDR;
			HDR_EXHIROM:          hdr_base = `EXHIROM_HDR;
			default: begin
				hdr_base   = '0;
				hdr_forced = 1'b0;
			end
		endcase
	end

	assign rom_fld_addr = hdr_base + `HDR_SKIP;
	assign ram_fld_addr = rom_fld_addr + `DL_ADDR_BITS'(2);

	// Next sizes, so the masks follow on the same write
	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		if (dl_addr == '0) begin
			// Defaults first, then the packed size byte in auto mode
			rom_size_nxt = 4'hC;
			ram_size_nxt = 4'h0;
			if (hdr_sel == HDR_AUTO && dl_data[7:0] != 8'h00) begin
				{ram_size_nxt, rom_size_nxt} = dl_data[7:0];
			end
		end
		if (hdr_forced && dl_addr == rom_fld_addr) rom_size_nxt = dl_data[11:8];
		if (hdr_forced && dl_addr == ram_fld_addr) ram_size_nxt = dl_data[3:0];
	end

	// ==============================
	// Header capture
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= '0;
			ram_size   <= '0;
			rom_type   <= '0;
			rom_region <= 1'b0;
			rom_mask   <= '0;
			ram_mask   <= '0;
		end else if (hdr_wr) begin
			rom_size <= rom_size_nxt;
			ram_size <= ram_size_nxt;
			if (dl_addr == '0) begin
				case (hdr_sel)
					HDR_NOHDR, HDR_LOROM: rom_type <= 8'd0;
					HDR_HIROM:            rom_type <= 8'd1;
					HDR_EXHIROM:          rom_type <= 8'd2;
					default:              rom_type <= dl_data[15:8];
				endcase
			end
			// Region bit of the image
			if (dl_addr == `DL_ADDR_BITS'(2)) rom_region <= dl_data[8];
			rom_mask <= (mask_t'(1024) << rom_size_nxt) - mask_t'(1);
			// Zero RAM size means no backup RAM at all
			ram_mask <= (ram_size_nxt != 4'h0) ? (mask_t'(1024) << ram_size_nxt) - mask_t'(1) : '0;
		end
	end

	// Region only settles outside a download
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			region <= 1'b0;
		end else if (!cart_dl) begin
			region <= (region_sel == 2'b00) ? rom_region : region_sel[1];
		end
	end

endmodule

//--- logic/ram_clear_counter.sv
`timescale 1ns/1ps
`include "cart_defines.svh"

module ram_clear_counter
	import cart_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  logic                       cart_dl,
	input  wram_init_t                 wram_init,
	output logic                       clearing,
	output logic [`WRAM_ADDR_BITS-1:0] fill_addr,
	output byte_t                      fill_byte
);

	// Pattern bytes split from the paired fill words
	localparam logic [15:0] PAT_A = `FILL_A;
	localparam logic [15:0] PAT_B = `FILL_B;
	localparam byte_t       PAT_C = `FILL_C;

	logic cart_dl_d;

	// ==============================
	// Sweep over the whole work RAM
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_d <= 1'b0;
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			cart_dl_d <= cart_dl;
			if (clearing) begin
				fill_addr <= fill_addr + 1'b1;
				// Last address written, counter wraps back to zero
				if (&fill_addr) clearing <= 1'b0;
			end else begin
				fill_addr <= '0;
				// Start of a cartridge download
				if (cart_dl && !cart_dl_d) clearing <= 1'b1;
			end
		end
	end

	// Fill byte from the current sweep address
	always_comb begin
		case (wram_init)
			WRAM_INIT_6699: begin
				fill_byte = (fill_addr[8] ^ fill_addr[2]) ? PAT_A[15:8] : PAT_A[7:0];
			end
			WRAM_INIT_FF00: begin
				fill_byte = (fill_addr[9] ^ fill_addr[0]) ? PAT_B[15:8] : PAT_B[7:0];
			end
			WRAM_INIT_55: begin
				fill_byte = PAT_C;
			end
			// Plain FF
			default: begin
				fill_byte = PAT_B[15:8];
			end
		endcase
	end

endmodule

//--- logic/cart_ram.sv
`timescale 1ns/1ps

module cart_ram
	import cart_pkg::*;
#(
	parameter type payload_t = byte_t,
	parameter int  ADDR_BITS = 8
)
(
	input  logic                 clk_sys,
	// Port A
	input  logic [ADDR_BITS-1:0] addr_a,
	input  payload_t             d_a,
	input  logic                 we_a,
	output payload_t             q_a,
	// Port B
	input  logic [ADDR_BITS-1:0] addr_b,
	input  payload_t             d_b,
	input  logic                 we_b,
	output payload_t             q_b
);

	localparam int DEPTH = 1 << ADDR_BITS;

	payload_t mem [0:DEPTH-1];

	// ==============================
	// Storage
	// ==============================

	// Both ports write in one process
	// Port B wins when the addresses collide
	always_ff @(posedge clk_sys) begin
		if (we_a) mem[addr_a] <= d_a;
		if (we_b) mem[addr_b] <= d_b;
	end

	// Registered reads, old data on a read during write
	always_ff @(posedge clk_sys) begin
		q_a <= mem[addr_a];
		q_b <= mem[addr_b];
	end

endmodule

//--- logic/backup_sector_fsm.sv
`timescale 1ns/1ps

module backup_sector_fsm
	import cart_pkg::*;
(
	input  logic  clk_sys,
	input  logic  RESET,
	input  logic  cart_dl,
	input  mask_t ram_mask,
	input  logic  img_mounted,
	input  logic  img_readonly,
	input  logic  img_present,
	input  logic  load_req,
	input  logic  save_req,
	input  logic  bsram_we,
	input  logic  sd_ack,
	output logic  sd_rd,
	output logic  sd_wr,
	output lba_t  sd_lba,
	output logic  bk_busy,
	output logic  bk_loading,
	output logic  bk_pending
);

	typedef enum logic {ST_IDLE, ST_XFER} state_t;

	state_t state;
	logic   bk_ena;
	logic   cart_dl_d;
	logic   load_q, load_qq;
	logic   save_q, save_qq;
	logic   ack_d;
	logic   load_start, save_start, auto_start;
	logic   job_start, job_load;
	logic   ack_rise, ack_fall;
	logic   last_sector;

	// Requests are registered once, then edge detected
	assign load_start  = load_q & ~load_qq & bk_ena;
	assign save_start  = save_q & ~save_qq & bk_ena;
	// Download just ended with a save image behind it
	assign auto_start  = cart_dl_d & ~cart_dl & img_present & bk_ena;
	assign job_start   = (state == ST_IDLE) & (load_start | save_start | auto_start);
	assign job_load    = load_start | auto_start;
	assign ack_rise    = sd_ack & ~ack_d;
	assign ack_fall    = ack_d & ~sd_ack;
	// One sector per 512 bytes of backup RAM
	assign last_sector = (sd_lba >= lba_t'(ram_mask[23:9]));
	assign bk_busy     = (state == ST_XFER);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_d <= 1'b0;
			load_q    <= 1'b0;
			load_qq   <= 1'b0;
			save_q    <= 1'b0;
			save_qq   <= 1'b0;
			ack_d     <= 1'b0;
			bk_ena    <= 1'b0;
		end else begin
			cart_dl_d <= cart_dl;
			load_q    <= load_req;
			load_qq   <= load_q;
			save_q    <= save_req;
			save_qq   <= save_q;
			ack_d     <= sd_ack;
			// New download drops backup until the image is seen again
			if (cart_dl && !cart_dl_d) bk_ena <= 1'b0;
			if (cart_dl && img_mounted && !img_readonly) bk_ena <= |ram_mask;
		end
	end

	// ==============================
	// Sector sequencing
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= ST_IDLE;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			bk_loading <= 1'b0;
		end else begin
			// Host took the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			case (state)
				ST_IDLE: begin
					if (job_start) begin
						state      <= ST_XFER;
						bk_loading <= job_load;
						sd_lba     <= '0;
						sd_rd      <= job_load;
						sd_wr      <= ~job_load;
					end
				end
				ST_XFER: begin
					if (ack_fall) begin
						if (last_sector) begin
							state      <= ST_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + lba_t'(1);
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Unsaved writes from the emulated system
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_pending <= 1'b0;
		end else if (bk_ena && bsram_we) begin
			bk_pending <= 1'b1;
		end else if (job_start || !bk_ena) begin
			bk_pending <= 1'b0;
		end
	end

endmodule

//--- logic/cart_loader_top.sv
`timescale 1ns/1ps
`include "cart_defines.svh"

module cart_loader_top
	import cart_pkg::*;
(
	input  logic                          clk_sys,
	input  logic                          RESET,
	// Host download
	input  logic                          dl_active,
	input  byte_t                         dl_index,
	input  logic [`DL_ADDR_BITS-1:0]      dl_addr,
	input  word_t                         dl_data,
	input  logic                          dl_wr,
	// Host sectors
	output logic                          sd_rd,
	output logic                          sd_wr,
	output lba_t                          sd_lba,
	input  logic                          sd_ack,
	input  logic [`SECTOR_WORDS_BITS-1:0] sd_buff_addr,
	input  word_t                         sd_buff_dout,
	output word_t                         sd_buff_din,
	input  logic                          sd_buff_wr,
	input  logic                          img_mounted,
	input  logic                          img_readonly,
	input  logic                          img_present,
	// Options and requests
	input  hdr_sel_t                      hdr_sel,
	input  logic [1:0]                    region_sel,
	input  wram_init_t                    wram_init,
	input  logic                          load_req,
	input  logic                          save_req,
	// Emulated system
	input  logic [`WRAM_ADDR_BITS-1:0]    wram_addr,
	input  byte_t                         wram_d,
	input  logic                          wram_we,
	output byte_t                         wram_q,
	input  logic [`BSRAM_ADDR_BITS-1:0]   bsram_addr,
	input  word_t                         bsram_d,
	input  logic                          bsram_we,
	output word_t                         bsram_q,
	// Status
	output byte_t                         rom_type,
	output mask_t                         rom_mask,
	output mask_t                         ram_mask,
	output logic                          region,
	output logic                          clearing,
	output logic                          hold_reset,
	output logic                          bk_busy,
	output logic                          bk_pending
);

	localparam int LBA_LOW_BITS = `BSRAM_ADDR_BITS - `SECTOR_WORDS_BITS;

	logic                       cart_dl;
	logic                       bk_loading;
	logic [`WRAM_ADDR_BITS-1:0] fill_addr;
	byte_t                      fill_byte;

	// Cartridge images use index zero in the low six bits
	assign cart_dl    = dl_active & (dl_index[5:0] == 6'd0);
	// System stays in reset through download, clear and load
	assign hold_reset = RESET | cart_dl | clearing | bk_loading;

	cart_header_detect i_hdr (
		.clk_sys(clk_sys), .RESET(RESET), .cart_dl(cart_dl),
		.dl_addr(dl_addr), .dl_data(dl_data), .dl_wr(dl_wr),
		.hdr_sel(hdr_sel), .region_sel(region_sel),
		.rom_type(rom_type), .rom_mask(rom_mask), .ram_mask(ram_mask), .region(region)
	);

	ram_clear_counter i_clr (
		.clk_sys(clk_sys), .RESET(RESET), .cart_dl(cart_dl), .wram_init(wram_init),
		.clearing(clearing), .fill_addr(fill_addr), .fill_byte(fill_byte)
	);

	backup_sector_fsm i_bk (
		.clk_sys(clk_sys), .RESET(RESET), .cart_dl(cart_dl), .ram_mask(ram_mask),
		.img_mounted(img_mounted), .img_readonly(img_readonly), .img_present(img_present),
		.load_req(load_req), .save_req(save_req), .bsram_we(bsram_we), .sd_ack(sd_ack),
		.sd_rd(sd_rd), .sd_wr(sd_wr), .sd_lba(sd_lba),
		.bk_busy(bk_busy), .bk_loading(bk_loading), .bk_pending(bk_pending)
	);

	// ==============================
	// Memories
	// ==============================

	// Work RAM, B port belongs to the clear sweep
	cart_ram #(.payload_t(byte_t), .ADDR_BITS(`WRAM_ADDR_BITS)) i_wram (
		.clk_sys(clk_sys),
		.addr_a(wram_addr), .d_a(wram_d), .we_a(wram_we), .q_a(wram_q),
		.addr_b(fill_addr), .d_b(fill_byte), .we_b(clearing), .q_b()
	);

	// Backup RAM, A port forced to all ones while clearing
	cart_ram #(.payload_t(word_t), .ADDR_BITS(`BSRAM_ADDR_BITS)) i_bsram (
		.clk_sys(clk_sys),
		.addr_a(clearing ? fill_addr[`BSRAM_ADDR_BITS-1:0] : bsram_addr),
		.d_a(clearing ? '1 : bsram_d),
		.we_a(clearing | bsram_we),
		.q_a(bsram_q),
		// Sector buffer window into backup RAM
		.addr_b({sd_lba[LBA_LOW_BITS-1:0], sd_buff_addr}),
		.d_b(sd_buff_dout),
		.we_b(sd_buff_wr & sd_ack),
		.q_b(sd_buff_din)
	);

endmodule

//--- verification/cart_loader_assertions.sv
`timescale 1ns/1ps

module cart_loader_assertions (
	input logic clk_sys,
	input logic RESET,
	input logic cart_dl,
	input logic clearing,
	input logic sd_rd,
	input logic sd_wr,
	input logic sd_ack
);

	// ==============================
	// Sector handshake
	// ==============================

	// Only one kind of request at a time
	a_one_request : assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high together");

	// Request drops right after the host acknowledges
	a_req_drop : assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(sd_ack) |=> !(sd_rd || sd_wr))
		else $error("request still high after ack rise");

	// Clear sweep starts only inside a cartridge download
	a_clear_in_dl : assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(clearing) |-> cart_dl)
		else $error("clearing rose outside a download");

endmodule

bind cart_loader_top cart_loader_assertions i_asrt (
	.clk_sys(clk_sys), .RESET(RESET), .cart_dl(cart_dl), .clearing(clearing),
	.sd_rd(sd_rd), .sd_wr(sd_wr), .sd_ack(sd_ack)
);

//--- verification/cart_loader_tb.sv
`timescale 1ns/1ps
`include "cart_defines.svh"

module cart_loader_tb
	import cart_pkg::*;
();

	// Run limit from the clear sweep and two jobs of up to 8 sectors per case
	localparam int CASES_MAX = 8;
	localparam int LIMIT = CASES_MAX * ((1 << 17) + 2 * 8 * 300 + 400) + 2000;

	logic clk_sys = 1'b0;
	logic RESET, dl_active, dl_wr, sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic img_mounted, img_readonly, img_present, load_req, save_req;
	logic wram_we, bsram_we, region, clearing, hold_reset, bk_busy, bk_pending;
	byte_t dl_index, wram_d, wram_q, rom_type;
	logic [24:0] dl_addr;
	word_t dl_data, sd_buff_dout, sd_buff_din, bsram_d, bsram_q;
	lba_t sd_lba;
	logic [7:0] sd_buff_addr;
	hdr_sel_t hdr_sel;
	logic [1:0] region_sel;
	wram_init_t wram_init;
	logic [16:0] wram_addr;
	logic [15:0] bsram_addr;
	mask_t rom_mask, ram_mask;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	integer seed = 32'hf08d_093a;
	// Expected backup RAM contents
	word_t bk_model [0:65535];

	cart_loader_top i_dut (.*);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout, the run passed %0d cycles without finishing", LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Power-on work RAM pattern
	function automatic byte_t fill_expect(input wram_init_t init, input logic [16:0] a);
		case (init)
			2'd0: return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			2'd1: return (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			2'd2: return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	task automatic write_dl(input logic [24:0] a, input word_t d);
		@(negedge clk_sys);
		dl_addr = a;
		dl_data = d;
		dl_wr = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
	endtask

	task automatic read_wram(input logic [16:0] a, output byte_t q);
		@(negedge clk_sys);
		wram_addr = a;
		@(negedge clk_sys);
		q = wram_q;
	endtask

	task automatic read_bsram(input logic [15:0] a, output word_t q);
		@(negedge clk_sys);
		bsram_addr = a;
		@(negedge clk_sys);
		q = bsram_q;
	endtask

	// Host side of a load with random words into each sector
	task automatic serve_load(input int nsec);
		logic [31:0] rnd;
		for (int s = 0; s < nsec; s++) begin
			while (!(sd_rd || sd_wr)) @(negedge clk_sys);
			check("load sd_lba", sd_lba, s);
			check("load sd_rd", sd_rd, 1);
			@(negedge clk_sys);
			sd_ack = 1'b1;
			for (int i = 0; i < 256; i++) begin
				@(negedge clk_sys);
				rnd = $random(seed);
				sd_buff_addr = i[7:0];
				sd_buff_dout = rnd[15:0];
				sd_buff_wr = 1'b1;
				bk_model[s * 256 + i] = rnd[15:0];
			end
			@(negedge clk_sys);
			sd_buff_wr = 1'b0;
			sd_ack = 1'b0;
		end
	endtask

	// Host side of a save where data trails the address by one cycle
	task automatic serve_save(input int nsec);
		for (int s = 0; s < nsec; s++) begin
			while (!(sd_rd || sd_wr)) @(negedge clk_sys);
			check("save sd_lba", sd_lba, s);
			check("save sd_wr", sd_wr, 1);
			check("pending cleared by save", bk_pending, 0);
			@(negedge clk_sys);
			sd_ack = 1'b1;
			for (int i = 0; i <= 256; i++) begin
				@(negedge clk_sys);
				if (i > 0) check("save word", sd_buff_din, bk_model[s * 256 + i - 1]);
				if (i < 256) sd_buff_addr = i[7:0];
			end
			sd_ack = 1'b0;
		end
	endtask

	initial begin
		integer fd;
		int n;
		int nsec;
		string line;
		logic [31:0] sel, rsel, init, img, w0, w2, wrom, wram, e_type, e_rom, e_ram;
		logic [31:0] rnd;
		logic [24:0] base;
		byte_t bq;
		word_t wq;
		RESET = 1'b1;
		{dl_active, dl_wr, sd_ack, sd_buff_wr, img_mounted, img_readonly} = '0;
		{img_present, load_req, save_req, wram_we, bsram_we} = '0;
		{dl_index, dl_addr, dl_data, sd_buff_addr, sd_buff_dout, wram_d, bsram_d} = '0;
		{hdr_sel, region_sel, wram_init, wram_addr, bsram_addr} = '0;
		repeat (10) @(negedge clk_sys);
		RESET = 1'b0;
		repeat (2) @(negedge clk_sys);
		check("clearing after reset", clearing, 0);
		check("bk_busy after reset", bk_busy, 0);
		check("bk_pending after reset", bk_pending, 0);
		check("hold_reset after reset", hold_reset, 0);
		fd = $fopen("verification/cart_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			errors++;
		end
		while (fd != 0 && !$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 4 || line.getc(0) == 8'h23) continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
				sel, rsel, init, img, w0, w2, wrom, wram, e_type, e_rom, e_ram);
			if (n != 11) continue;
			for (int k = 0; k < 65536; k++) bk_model[k] = 16'hFFFF;
			// ==============================
			// Download with header
			// ==============================
			@(negedge clk_sys);
			hdr_sel = sel[2:0];
			region_sel = rsel[1:0];
			wram_init = init[1:0];
			img_mounted = img[0];
			img_present = img[0];
			dl_active = 1'b1;
			write_dl(25'd0, w0[15:0]);
			write_dl(25'd2, w2[15:0]);
			if (sel != 0) begin
				base = (sel == 3) ? `HIROM_HDR : (sel == 4) ? `EXHIROM_HDR : `LOROM_HDR;
				write_dl(base + `HDR_SKIP, wrom[15:0]);
				write_dl(base + `HDR_SKIP + 25'd2, wram[15:0]);
			end
			check("clearing during download", clearing, 1);
			while (clearing) @(negedge clk_sys);
			check("rom_type", rom_type, e_type);
			check("rom_mask", rom_mask, e_rom);
			check("ram_mask", ram_mask, e_ram);
			// Sampled addresses across the whole sweep
			for (int k = 0; k < 8; k++) begin
				read_wram(17'(k * 24593 + 291), bq);
				check("wram fill", bq, fill_expect(init[1:0], 17'(k * 24593 + 291)));
			end
			for (int k = 0; k < 4; k++) begin
				read_bsram(16'(k * 9001 + 77), wq);
				check("bsram fill", wq, 16'hFFFF);
			end
			@(negedge clk_sys);
			dl_active = 1'b0;
			repeat (3) @(negedge clk_sys);
			check("region", region, (rsel == 0) ? w2[8] : rsel[1]);
			if (img[0] && e_ram != 0) begin
				nsec = int'(e_ram[23:9]) + 1;
				serve_load(nsec);
				while (bk_busy) @(negedge clk_sys);
				check("hold_reset after load", hold_reset, 0);
				for (int k = 0; k < 4; k++) begin
					read_bsram(16'((k % nsec) * 256 + k * 61), wq);
					check("loaded word", wq, bk_model[(k % nsec) * 256 + k * 61]);
				end
				// Emulated system write followed by a save
				@(negedge clk_sys);
				rnd = $random(seed);
				bsram_addr = 16'h0105;
				bsram_d = rnd[15:0];
				bsram_we = 1'b1;
				bk_model[16'h0105] = rnd[15:0];
				@(negedge clk_sys);
				bsram_we = 1'b0;
				check("bk_pending after write", bk_pending, 1);
				save_req = 1'b1;
				repeat (4) @(negedge clk_sys);
				save_req = 1'b0;
				serve_save(nsec);
				while (bk_busy) @(negedge clk_sys);
			end
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- verification/cart_stimulus.txt
# hdr_sel region_sel wram_init img | word0 word2 rom_field ram_field | type rom_mask ram_mask
# All values hex, the field words are only written for a forced header choice
0 0 0 1 2021 0100 0000 0000 20 0007ff 000fff
0 2 1 0 3100 0000 0000 0000 31 3fffff 000000
2 0 2 1 55aa 0000 0a00 0001 00 0fffff 0007ff
3 1 3 0 0000 0100 0b00 0003 01 1fffff 001fff
4 0 0 1 0000 0100 0d00 0001 02 7fffff 0007ff
1 3 1 0 0000 0000 0800 0000 00 03ffff 000000

//--- filelist.f
+incdir+logic
logic/cart_pkg.sv
logic/cart_header_detect.sv
logic/ram_clear_counter.sv
logic/cart_ram.sv
logic/backup_sector_fsm.sv
logic/cart_loader_top.sv
verification/cart_loader_assertions.sv
verification/cart_loader_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "test   build with Verilator, run the testbench, check $(LOG)"
	@echo "clean  remove build output and $(LOG)"

test:
	verilator --binary --assert -Wno-fatal --top-module cart_loader_tb -f filelist.f -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
